/* src.f */
logic/fetch_pkg.sv
logic/fetch_control.sv
logic/fetch_pc.sv
logic/fetch_response_filter.sv
logic/fetch_bundle_queue.sv
logic/fetch_top.sv
testbench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the fetch stage with Verilator and runs the testbench
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module fetch_tb -o fetch_sim

# the simulation's own exit status is not trusted, the log decides
./obj_dir/fetch_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL, see sim.log"
	exit 1
fi

/* testbench/fetch_tb.sv */
// fetch stage testbench; memory answers in order after 1 to 4 cycles, decode returns one credit per bundle
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*;
();

	localparam int CLK_PERIOD      = 4;          // ns
	localparam int RESET_CYCLES    = 10;
	localparam int QUEUE_DEPTH     = 4;
	localparam int DECODE_CREDITS  = 2;
	localparam int SEQ_BUNDLES     = 16;         // plain sequential fetch
	localparam int RESUME_BUNDLES  = 8;          // after an enable gap
	localparam int REDIR_BUNDLES   = 10;         // after each redirect with requests in flight
	localparam int IDLE_BUNDLES    = 8;          // after a redirect taken while disabled
	localparam int PLANNED_BUNDLES = SEQ_BUNDLES + RESUME_BUNDLES + 2 * REDIR_BUNDLES + IDLE_BUNDLES;
	localparam int CYCLES_PER_BUNDLE = 40;       // watchdog budget

	logic    clock;
	logic    reset;
	logic    fetch_enable;
	logic    redirect_valid;
	pc_t     redirect_pc;
	logic    imem_req_valid;
	pc_t     imem_req_addr;
	logic    imem_grant      = 1'b0;
	logic    imem_resp_valid = 1'b0;
	bundle_t imem_resp_data  = '0;
	logic    out_valid;
	pc_t     out_pc;
	inst_t   out_inst1;
	inst_t   out_inst2;
	logic    credit_return   = 1'b0;

	integer  seed        = 32'h9b71;             // one stream, drawn only at fixed points
	int      model_cycle = 0;
	int      resp_due[$];                        // edge at which each response is sampled
	pc_t     resp_addr[$];
	int      credit_due[$];
	int      last_resp_due;
	int      last_credit_due;

	pc_t     ref_pc;                             // next pc decode should see
	pc_t     redirect_target;
	logic    await_target;                       // first bundle after a redirect still due
	int      tb_credits;
	int      delivered;
	logic    seen_req;
	logic    hold_q;                             // last edge had no grant and no redirect
	pc_t     prev_addr;
	int      error_count = 0;

	fetch_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .DECODE_CREDITS(DECODE_CREDITS)) u_dut (
		.clock(clock), .reset(reset), .fetch_enable(fetch_enable),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.imem_req_valid(imem_req_valid), .imem_req_addr(imem_req_addr),
		.imem_grant(imem_grant), .imem_resp_valid(imem_resp_valid),
		.imem_resp_data(imem_resp_data), .out_valid(out_valid), .out_pc(out_pc),
		.out_inst1(out_inst1), .out_inst2(out_inst2), .credit_return(credit_return)
	);

	////////////////////
	// helpers
	////////////////////

	// memory content: first inst is the address, second is address plus 4
	function automatic bundle_t mem_word(input pc_t addr);
		mem_word = {addr[31:0], addr[31:0] + 32'd4};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count = error_count + 1;
		$display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
			$time, name, expected, actual);
		$display("Regression failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic fail_run(input string reason);
		error_count = error_count + 1;
		$display("ERROR time=%0t %s", $time, reason);
		$display("Regression failed");
		$fatal(1, "stopping at the first error");
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////
	// memory and decode models
	////////////////////

	always @(posedge clock)
	begin : models
		int due;
		model_cycle = model_cycle + 1;           // number of this edge
		if (reset)
		begin
			resp_due.delete();
			resp_addr.delete();
			credit_due.delete();
			last_resp_due   = 0;
			last_credit_due = 0;
		end
		else
		begin
			if (imem_req_valid && imem_grant)
			begin
				due = model_cycle + 1 + int'($unsigned($random(seed)) % 4);
				if (due <= last_resp_due)
					due = last_resp_due + 1;     // keep responses in order, one per cycle
				last_resp_due = due;
				resp_due.push_back(due);
				resp_addr.push_back(imem_req_addr);
			end
			if (out_valid)
			begin
				due = model_cycle + 1 + int'($unsigned($random(seed)) % 4);
				if (due <= last_credit_due)
					due = last_credit_due + 1;   // single credit wire
				last_credit_due = due;
				credit_due.push_back(due);
			end
		end
		#1;
		imem_grant      = ($unsigned($random(seed)) % 4) != 0;  // withheld about one in four
		imem_resp_valid = 1'b0;
		credit_return   = 1'b0;
		if (resp_due.size() != 0 && resp_due[0] == model_cycle + 1)
		begin
			imem_resp_valid = 1'b1;
			imem_resp_data  = mem_word(resp_addr.pop_front());
			void'(resp_due.pop_front());
		end
		if (credit_due.size() != 0 && credit_due[0] == model_cycle + 1)
		begin
			credit_return = 1'b1;
			void'(credit_due.pop_front());
		end
	end

	////////////////////
	// reference model
	////////////////////

	always @(posedge clock)
	begin
		if (reset)
		begin
			ref_pc       <= RESET_PC;
			await_target <= 1'b0;
			tb_credits   <= DECODE_CREDITS;
			delivered    <= 0;
			seen_req     <= 1'b0;
			hold_q       <= 1'b0;
		end
		else
		begin
			if (out_valid)
			begin
				ref_pc       <= ref_pc + pc_t'(FETCH_BYTES);  // one bundle per delivery
				delivered    <= delivered + 1;
				await_target <= 1'b0;
			end
			if (redirect_valid)
			begin
				ref_pc          <= redirect_pc;   // wins over a same-edge delivery
				redirect_target <= redirect_pc;
				await_target    <= 1'b1;
			end
			tb_credits <= tb_credits - int'(out_valid) + int'(credit_return);
			if (imem_req_valid)
				seen_req <= 1'b1;
			hold_q <= !imem_grant && !redirect_valid;
		end
		prev_addr <= imem_req_addr;
	end

	////////////////////
	// checks
	////////////////////

	a_out_pc: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_pc == ref_pc)
		else report_mismatch("out_pc", ref_pc, out_pc);

	a_inst1: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_inst1 == ref_pc[31:0])
		else report_mismatch("out_inst1", ref_pc[31:0], out_inst1);

	a_inst2: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_inst2 == ref_pc[31:0] + 32'd4)
		else report_mismatch("out_inst2", ref_pc[31:0] + 32'd4, out_inst2);

	// nothing from the abandoned path may come first
	a_target_first: assert property (@(posedge clock) disable iff (reset)
		out_valid && await_target |-> out_pc == redirect_target)
		else report_mismatch("out_pc", redirect_target, out_pc);

	a_credit: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> tb_credits != 0)
		else fail_run("out_valid was high while decode held no credit");

	a_addr_hold: assert property (@(posedge clock) disable iff (reset)
		hold_q |-> imem_req_addr == prev_addr)
		else report_mismatch("imem_req_addr", prev_addr, imem_req_addr);

	a_enable_low: assert property (@(posedge clock) disable iff (reset)
		!fetch_enable |-> !imem_req_valid)
		else report_mismatch("imem_req_valid", 1'b0, imem_req_valid);

	a_first_req: assert property (@(posedge clock) disable iff (reset)
		imem_req_valid && !seen_req |-> imem_req_addr == RESET_PC)
		else report_mismatch("imem_req_addr", RESET_PC, imem_req_addr);

	a_reset_quiet: assert property (@(posedge clock)
		$fell(reset) |-> !out_valid && !imem_req_valid)
		else fail_run("out_valid or imem_req_valid was high right after reset");

	a_reset_state: assert property (@(posedge clock)
		$fell(reset) |-> u_dut.u_control.fetch_state == FETCH_IDLE)
		else report_mismatch("fetch_state", FETCH_IDLE, u_dut.u_control.fetch_state);

	////////////////////
	// stimulus
	////////////////////

	task automatic wait_bundles(input int count);
		int target;
		target = delivered + count;
		while (delivered < target)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic wait_inflight();
		while (u_dut.inflight_count == '0)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic redirect_to(input pc_t target);
		redirect_valid = 1'b1;
		redirect_pc    = target;
		@(posedge clock);
		#1;
		redirect_valid = 1'b0;
	endtask

	// two redirects on consecutive cycles, the second one counts
	task automatic redirect_pair(input pc_t first, input pc_t second);
		redirect_valid = 1'b1;
		redirect_pc    = first;
		@(posedge clock);
		#1;
		redirect_pc    = second;
		@(posedge clock);
		#1;
		redirect_valid = 1'b0;
	endtask

	initial
	begin : stimulus
		pc_t far_target;
		far_target      = {$random(seed), $random(seed)};  // drawn before the models start
		far_target[2:0] = 3'b000;
		reset          = 1'b1;
		fetch_enable   = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		fetch_enable = 1'b1;
		wait_bundles(SEQ_BUNDLES);
		fetch_enable = 1'b0;                     // gap, no requests allowed
		repeat (12) @(posedge clock);
		#1;
		fetch_enable = 1'b1;
		wait_bundles(RESUME_BUNDLES);
		wait_inflight();
		redirect_to(64'h1000);                   // stale responses still on their way
		wait_bundles(REDIR_BUNDLES);
		wait_inflight();
		redirect_pair(64'h2000, far_target);
		wait_bundles(REDIR_BUNDLES);
		fetch_enable = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		redirect_to(64'h40);                     // taken while idle
		repeat (4) @(posedge clock);
		#1;
		fetch_enable = 1'b1;
		wait_bundles(IDLE_BUNDLES);
		repeat (4) @(posedge clock);
		if (error_count == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			fail_run("checks failed during the run");
	end

	initial
	begin : watchdog
		#(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_BUNDLE * PLANNED_BUNDLES));
		fail_run("watchdog expired before all planned bundles were delivered");
	end

endmodule

/* logic/fetch_top.sv */
// fetch stage top; memory must return responses in order, decode returns one credit per bundle
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*;
#(
	parameter int QUEUE_DEPTH    = 4,                          // bundle queue entries
	parameter int DECODE_CREDITS = 2,                          // initial decode credits
	parameter int COUNT_W        = $clog2(QUEUE_DEPTH + 1)     // holds 0..QUEUE_DEPTH
)
(
	input  logic    clock,
	input  logic    reset,
	input  logic    fetch_enable,
	input  logic    redirect_valid,
	input  pc_t     redirect_pc,

	output logic    imem_req_valid,
	output pc_t     imem_req_addr,
	input  logic    imem_grant,
	input  logic    imem_resp_valid,
	input  bundle_t imem_resp_data,

	output logic    out_valid,
	output pc_t     out_pc,
	output inst_t   out_inst1,
	output inst_t   out_inst2,
	input  logic    credit_return
);

	logic               issue;
	logic               flush;
	pc_t                req_pc;
	logic               push;
	pc_t                push_pc;
	bundle_t            push_data;
	logic [COUNT_W-1:0] inflight_count;
	logic [COUNT_W-1:0] free_slots;

	assign imem_req_valid = issue;   // request valid is the issue decision itself

	fetch_control #(.COUNT_W(COUNT_W)) u_control (
		.clock(clock), .reset(reset), .fetch_enable(fetch_enable),
		.redirect_valid(redirect_valid), .imem_grant(imem_grant),
		.free_slots(free_slots), .inflight_count(inflight_count),
		.issue(issue), .flush(flush),
		.fetch_state()                // state is watched hierarchically
	);

	fetch_pc u_pc (
		.clock(clock), .reset(reset), .issue(issue), .imem_grant(imem_grant),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.imem_req_addr(imem_req_addr), .req_pc(req_pc)
	);

	fetch_response_filter #(.QUEUE_DEPTH(QUEUE_DEPTH), .COUNT_W(COUNT_W)) u_filter (
		.clock(clock), .reset(reset), .issue(issue), .imem_grant(imem_grant),
		.flush(flush), .req_pc(req_pc),
		.imem_resp_valid(imem_resp_valid), .imem_resp_data(imem_resp_data),
		.push(push), .push_pc(push_pc), .push_data(push_data),
		.inflight_count(inflight_count)
	);

	fetch_bundle_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH), .DECODE_CREDITS(DECODE_CREDITS), .COUNT_W(COUNT_W)
	) u_queue (
		.clock(clock), .reset(reset), .flush(flush),
		.push(push), .push_pc(push_pc), .push_data(push_data),
		.credit_return(credit_return), .free_slots(free_slots),
		.out_valid(out_valid), .out_pc(out_pc),
		.out_inst1(out_inst1), .out_inst2(out_inst2)
	);

endmodule

/* logic/fetch_bundle_queue.sv */
// bundle queue with decode credits; decode must never return more credits than bundles it got
`timescale 1ns/10ps

module fetch_bundle_queue import fetch_pkg::*;
#(
	parameter int QUEUE_DEPTH    = 4,
	parameter int DECODE_CREDITS = 2,           // credits held after reset
	parameter int COUNT_W        = 3
)
(
	input  logic               clock,
	input  logic               reset,
	input  logic               flush,           // drop everything queued
	input  logic               push,
	input  pc_t                push_pc,
	input  bundle_t            push_data,
	input  logic               credit_return,   // decode freed one entry

	output logic [COUNT_W-1:0] free_slots,
	output logic               out_valid,       // one bundle to decode this cycle
	output pc_t                out_pc,
	output inst_t              out_inst1,
	output inst_t              out_inst2
);

	localparam int PTR_W    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CREDIT_W = $clog2(DECODE_CREDITS + 1);

	pc_t                 pc_mem   [QUEUE_DEPTH];
	bundle_t             data_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [COUNT_W-1:0]  count;                 // occupied entries
	logic [CREDIT_W-1:0] credits;               // bundles decode can still take
	logic                launch;                // head moves to the output register

	assign launch     = (count != '0) && (credits != '0) && !flush;
	assign free_slots = COUNT_W'(QUEUE_DEPTH) - count;

	////////////////////
	// pointers, credits
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			out_valid <= 1'b0;
			credits   <= CREDIT_W'(DECODE_CREDITS);
		end
		else
		begin
			out_valid <= launch;
			// spent on launch, so the next cycle already sees the lower count
			credits   <= credits - CREDIT_W'(launch) + CREDIT_W'(credit_return);
			if (flush)
			begin
				wr_ptr <= '0;                     // empty in the redirect edge
				rd_ptr <= '0;
				count  <= '0;
			end
			else
			begin
				if (push)
					wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				if (launch)
					rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				count <= count + COUNT_W'(push) - COUNT_W'(launch);
			end
		end
	end

	// payload, written and read by pointer only
	always_ff @(posedge clock)
	begin
		if (push)
		begin
			pc_mem[wr_ptr]   <= push_pc;
			data_mem[wr_ptr] <= push_data;
		end
		if (launch)
		begin
			out_pc    <= pc_mem[rd_ptr];
			out_inst1 <= data_mem[rd_ptr][BUNDLE_W-1:INST_W];  // upper half goes first
			out_inst2 <= data_mem[rd_ptr][INST_W-1:0];
		end
	end

	////////////////////
	// checks
	////////////////////

	// the control reservation should make this impossible
	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		push |-> count != COUNT_W'(QUEUE_DEPTH))
		else $error("push into a full bundle queue");

	a_credit_bound: assert property (@(posedge clock) disable iff (reset)
		credit_return && !launch |-> credits < CREDIT_W'(DECODE_CREDITS))
		else $error("decode returned more credits than it was given");

endmodule

/* logic/fetch_response_filter.sv */
// response filter; memory must answer in order, at most QUEUE_DEPTH requests may be outstanding
`timescale 1ns/10ps

module fetch_response_filter import fetch_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4,                // max requests in flight
	parameter int COUNT_W     = 3
)
(
	input  logic               clock,
	input  logic               reset,
	input  logic               issue,
	input  logic               imem_grant,
	input  logic               flush,           // redirect this cycle
	input  pc_t                req_pc,          // pc of the request being issued
	input  logic               imem_resp_valid,
	input  bundle_t            imem_resp_data,

	output logic               push,            // accepted bundle into the queue
	output pc_t                push_pc,
	output bundle_t            push_data,
	output logic [COUNT_W-1:0] inflight_count
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	pc_t                pc_fifo [QUEUE_DEPTH];  // pcs of outstanding requests, oldest at rd_ptr
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;                  // requests in flight
	logic [COUNT_W-1:0] drop_count;             // stale responses still to come
	logic               granted;

	assign granted        = issue && imem_grant;
	assign inflight_count = count;

	// stale responses are swallowed, and nothing enters the queue while it is flushed
	assign push      = imem_resp_valid && (drop_count == '0) && !flush;
	assign push_pc   = pc_fifo[rd_ptr];         // in order, so the oldest pc matches
	assign push_data = imem_resp_data;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			drop_count <= '0;
		end
		else
		begin
			if (granted)
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (imem_resp_valid)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			count <= count + COUNT_W'(granted) - COUNT_W'(imem_resp_valid);

			if (flush)
				drop_count <= count - COUNT_W'(imem_resp_valid);  // all still out are stale
			else if (imem_resp_valid && (drop_count != '0))
				drop_count <= drop_count - 1'b1;
		end
	end

	// pc storage
	always_ff @(posedge clock)
	begin
		if (granted)
			pc_fifo[wr_ptr] <= req_pc;
	end

	// each response has to belong to a granted request
	a_resp_expected: assert property (@(posedge clock) disable iff (reset)
		imem_resp_valid |-> count != '0)
		else $error("memory response with nothing in flight");

endmodule

/* logic/fetch_pc.sv */
// fetch pc register; steps by one bundle per granted request, a redirect overrides any stall
`timescale 1ns/10ps

module fetch_pc import fetch_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic issue,           // request presented this cycle
	input  logic imem_grant,      // memory took it
	input  logic redirect_valid,  // taken branch
	input  pc_t  redirect_pc,     // branch target

	output pc_t  imem_req_addr,   // bundle aligned address
	output pc_t  req_pc           // unmasked pc, travels with the request
);

	pc_t  pc_reg;                 // pc being fetched
	pc_t  next_pc;
	logic advance;                // request accepted, move on

	assign advance = issue && imem_grant;

	////////////////////
	// next pc
	////////////////////

	// target wins over everything, otherwise it would be lost during a stall
	always_comb
	begin
		if (redirect_valid)
		begin
			next_pc = redirect_pc;
		end
		else if (advance)
		begin
			next_pc = pc_reg + pc_t'(FETCH_BYTES);  // next sequential bundle
		end
		else
		begin
			next_pc = pc_reg;                       // no grant, hold the address
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			pc_reg <= RESET_PC;
		else
			pc_reg <= next_pc;
	end

	// memory only sees whole bundles
	assign imem_req_addr = {pc_reg[PC_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign req_pc        = pc_reg;

endmodule

/* logic/fetch_control.sv */
// fetch FSM; issue is combinational and never depends on imem_grant, room is reserved per request in flight
`timescale 1ns/10ps

module fetch_control import fetch_pkg::*;
#(
	parameter int COUNT_W = 3                   // width of slot and in-flight counters
)
(
	input  logic               clock,
	input  logic               reset,
	input  logic               fetch_enable,    // stage enable
	input  logic               redirect_valid,  // taken branch from execute
	input  logic               imem_grant,      // memory accepted the request
	input  logic [COUNT_W-1:0] free_slots,      // empty bundle queue entries
	input  logic [COUNT_W-1:0] inflight_count,  // requests waiting on a response

	output logic               issue,           // drives imem_req_valid
	output logic               flush,           // kill the old path
	output fetch_state_e       fetch_state
);

	fetch_state_e next_state;
	logic         room;                         // a slot left over after all in-flight responses

	////////////////////
	// issue decision
	////////////////////

	// every outstanding response already owns a queue slot, so a new request
	// needs one more than that
	assign room  = free_slots > inflight_count;

	assign issue = (fetch_state == FETCH_RUN) && fetch_enable && !redirect_valid && room;

	// redirect kills everything in flight and queued on the same edge
	assign flush = redirect_valid;

	////////////////////
	// state machine
	////////////////////

	always_comb
	begin
		next_state = fetch_state;              // hold by default
		case (fetch_state)
			FETCH_IDLE:
			begin
				if (redirect_valid)
					next_state = FETCH_REDIRECT;
				else if (fetch_enable)
					next_state = FETCH_RUN;        // first enabled cycle only moves the state
			end
			FETCH_RUN:
			begin
				if (redirect_valid)
					next_state = FETCH_REDIRECT;
				else if (!fetch_enable)
					next_state = FETCH_IDLE;
			end
			FETCH_REDIRECT:
			begin
				// bubble cycle, pc already holds the target
				if (redirect_valid)
					next_state = FETCH_REDIRECT;   // back to back redirects
				else if (fetch_enable)
					next_state = FETCH_RUN;
				else
					next_state = FETCH_IDLE;
			end
			default:
			begin
				next_state = FETCH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			fetch_state <= FETCH_IDLE;
		else
			fetch_state <= next_state;
	end

	////////////////////
	// checks
	////////////////////

	// each response still on its way owns a queue slot, stale ones included
	a_room_reserved: assert property (@(posedge clock) disable iff (reset)
		free_slots >= inflight_count)
		else $error("requests in flight exceed the free queue slots");

	// a request waiting on grant is only withdrawn by a disable or a redirect
	a_req_held: assert property (@(posedge clock) disable iff (reset)
		issue && !imem_grant |=> issue || !fetch_enable || redirect_valid)
		else $error("request dropped before grant");

endmodule

/* logic/fetch_pkg.sv */
// shared fetch types; 64-bit pc, bundles are 8-byte aligned pairs with the first instruction in the upper half
package fetch_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int PC_W        = 64;                  // full virtual address
	localparam int INST_W      = 32;                  // one instruction
	localparam int BUNDLE_W    = 2 * INST_W;          // raw memory word, two instructions

	// bytes per fetch, also the bundle alignment
	localparam int FETCH_BYTES = BUNDLE_W / 8;
	localparam int OFFSET_W    = $clog2(FETCH_BYTES); // low address bits cleared on requests

	////////////////////
	// types
	////////////////////

	typedef logic [PC_W-1:0]     pc_t;      // instruction address
	typedef logic [INST_W-1:0]   inst_t;    // single instruction
	typedef logic [BUNDLE_W-1:0] bundle_t;  // [63:32] first inst, [31:0] second inst

	// first fetch address after reset
	localparam pc_t RESET_PC = 64'h0;

	// fetch control states
	typedef enum logic [1:0]
	{
		FETCH_IDLE     = 2'd0,  // enable low, no requests
		FETCH_RUN      = 2'd1,  // sequential fetch, issue allowed
		FETCH_REDIRECT = 2'd2   // one bubble cycle while pc takes the target
	} fetch_state_e;

endpackage
